//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= tb_rp_analog_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the run printed the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
+incdir+verilog
+incdir+bench
verilog/rp_sample_pkg.sv
verilog/rp_clock_pkg.sv
verilog/rp_reset_seq.sv
verilog/rp_lock_timer.sv
verilog/rp_adc_front.sv
verilog/rp_dac_back.sv
verilog/rp_analog_top.sv
bench/tb_rp_analog_top.sv

//--- bench/tb_rp_checks.svh
`ifndef TB_RP_CHECKS_SVH
`define TB_RP_CHECKS_SVH

//////////////////////////////
// Random source
//////////////////////////////

logic [15:0] lfsr_q = 16'd48322;

// Galois LFSR, new bits enter at the bottom
function automatic logic [31:0] lfsr_bits(input int n);
  logic [31:0] val;
  val = '0;
  for (int i = 0; i < n; i++) begin
    val    = {val[30:0], lfsr_q[0]};
    lfsr_q = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? 16'hB400 : 16'h0000); // One step per bit
  end
  return val;
endfunction

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_adc(input string name, input adc_sample_t exp, input adc_sample_t act);
  if (act !== exp)
    stop_on_error($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_dac(input string name, input dac_code_t exp, input dac_code_t act);
  if (act !== exp)
    stop_on_error($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_count(input string name, input unlock_cnt_t exp, input unlock_cnt_t act);
  if (act !== exp)
    stop_on_error($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp)
    stop_on_error($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
endtask

//////////////////////////////
// Bounded wait
//////////////////////////////

// Polls run_o on falling edges
task automatic wait_run(input logic level, input int limit);
  int cyc;
  cyc = 0;
  while (run_o !== level) begin
    if (cyc >= limit) begin
      stop_on_error($sformatf("run_o did not go to %b within %0d cycles", level, limit));
    end else begin
      @(negedge adc_clk);
      cyc++;
    end
  end
endtask

`endif

//--- bench/tb_rp_analog_top.sv
`timescale 1ns/1ps

`include "rp_params.svh"

module tb_rp_analog_top;

  import rp_sample_pkg::*;
  import rp_clock_pkg::*;

  localparam int ADC_ROWS    = 8;   // 4 corners, 4 random
  localparam int DAC_ROWS    = 10;  // 6 fixed pairs, 4 random
  localparam int RUN_TIMEOUT = 100; // Sync plus settle fits well inside

  logic                      adc_clk = 1'b0;
  logic                      rst_n_i;
  logic                      pll_locked_i;
  logic                      digital_loop_i;
  adc_raw_t    [`RP_NCH-1:0] adc_raw_i;
  dac_sample_t [`RP_NCH-1:0] asg_dat_i;
  adc_sample_t [`RP_NCH-1:0] pid_dat_i;
  adc_sample_t [`RP_NCH-1:0] adc_dat_o;
  dac_code_t   [`RP_NCH-1:0] dac_dat_o;
  logic                      dac_rst_o;
  logic                      run_o;
  unlock_cnt_t               unlock_cnt_o;

  //////////////////////////////
  // Stimulus and expected tables
  //////////////////////////////

  // Zero slots get LFSR rows
  adc_raw_t    raw_tab [ADC_ROWS] = '{16'h0000, 16'h7FFF, 16'h8000, 16'hFFFF,
                                      16'h0, 16'h0, 16'h0, 16'h0};
  adc_sample_t adc_exp_tab [ADC_ROWS] = '{16'h7FFF, 16'h0000, 16'hFFFF, 16'h8000,
                                          16'h0, 16'h0, 16'h0, 16'h0};

  // Two in range, two overflows, lost pid top bit, one past full scale
  dac_sample_t asg_tab [DAC_ROWS] = '{14'sd100, -14'sd1000, 14'sd8000, -14'sd8000, 14'sd0,
                                      14'sd8191, 14'sd0, 14'sd0, 14'sd0, 14'sd0};
  adc_sample_t pid_tab [DAC_ROWS] = '{16'sd200, 16'sd250, 16'sd1000, -16'sd1000, 16'sh4000,
                                      16'sd1, 16'sd0, 16'sd0, 16'sd0, 16'sd0};
  dac_sample_t sat_tab [DAC_ROWS] = '{14'sd300, -14'sd750, 14'sd8191, 14'sh2000, 14'sh2000,
                                      14'sd8191, 14'sd0, 14'sd0, 14'sd0, 14'sd0};

  unlock_cnt_t cnt_before;
  int          drop_cyc; // Lock loss length
  int          src;      // Table row for a channel

  always #2 adc_clk = ~adc_clk; // 4 ns

  rp_analog_top rp_analog_top_i (.*);

  //////////////////////////////
  // Reference models
  //////////////////////////////

  // Sign bit kept, fifteen magnitude bits flipped
  function automatic adc_sample_t adc_model(input adc_raw_t raw);
    return adc_sample_t'(raw ^ 16'h7FFF);
  endfunction

  // 15-bit sum loses the pid top bit, then clamp to 14 bits
  function automatic dac_sample_t sat_model(input dac_sample_t asg, input adc_sample_t pid);
    logic signed [14:0] sum15;
    int                 v;
    sum15 = $signed({asg[13], asg}) + $signed(pid[14:0]);
    v     = sum15;
    if (v > 8191)
      v = 8191;
    else if (v < -8192)
      v = -8192;
    return dac_sample_t'(v);
  endfunction

  function automatic dac_code_t code_of(input dac_sample_t sat);
    return dac_code_t'(sat) ^ 14'h1FFF; // Negative slope
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  // Datapath parked, DAC held in reset
  task automatic verify_idle(input string name);
    check_bit({name, " run_o"}, 1'b0, run_o);
    check_bit({name, " dac_rst_o"}, 1'b1, dac_rst_o);
    for (int ch = 0; ch < `RP_NCH; ch++) begin
      check_adc({name, " adc_dat_o"}, '0, adc_dat_o[ch]);
      check_dac({name, " dac_dat_o"}, 14'h1FFF, dac_dat_o[ch]); // Zero code
    end
  endtask

  `include "tb_rp_checks.svh"

  initial begin
    rst_n_i        <= 1'b0;
    pll_locked_i   <= 1'b1;
    digital_loop_i <= 1'b0;
    adc_raw_i      <= '0;
    asg_dat_i      <= '0;
    pid_dat_i      <= '0;
    for (int r = 4; r < ADC_ROWS; r++) begin
      raw_tab[r]     = adc_raw_t'(lfsr_bits(16));
      adc_exp_tab[r] = adc_model(raw_tab[r]);
    end
    for (int r = 6; r < DAC_ROWS; r++) begin
      asg_tab[r] = dac_sample_t'(lfsr_bits(14));
      pid_tab[r] = adc_sample_t'(dac_sample_t'(lfsr_bits(14))); // Sign extended
      sat_tab[r] = sat_model(asg_tab[r], pid_tab[r]);
    end

    repeat (5) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    @(negedge adc_clk);
    verify_idle("reset");
    check_count("reset unlock_cnt_o", '0, unlock_cnt_o);
    wait_run(1'b1, RUN_TIMEOUT);
    check_bit("release dac_rst_o lag", 1'b1, dac_rst_o); // Register trails run by a cycle
    check_count("release unlock_cnt_o", '0, unlock_cnt_o); // No loss before first lock
    @(negedge adc_clk);
    check_bit("release dac_rst_o", 1'b0, dac_rst_o);

    // Channel 1 walks the table backwards
    for (int r = 0; r < ADC_ROWS; r++) begin
      @(posedge adc_clk);
      adc_raw_i[0] <= raw_tab[r];
      adc_raw_i[1] <= raw_tab[ADC_ROWS-1-r];
      @(posedge adc_clk);
      @(negedge adc_clk);
      check_adc($sformatf("adc row %0d ch0", r), adc_exp_tab[r], adc_dat_o[0]);
      check_adc($sformatf("adc row %0d ch1", r), adc_exp_tab[ADC_ROWS-1-r], adc_dat_o[1]);
    end

    //////////////////////////////
    // DAC path, then loopback
    //////////////////////////////

    for (int pass = 0; pass < 2; pass++) begin
      for (int r = 0; r < DAC_ROWS; r++) begin
        @(posedge adc_clk);
        digital_loop_i <= (pass == 1);
        for (int ch = 0; ch < `RP_NCH; ch++) begin
          src = (ch == 0) ? r : DAC_ROWS-1-r;
          asg_dat_i[ch] <= asg_tab[src];
          pid_dat_i[ch] <= pid_tab[src];
        end
        @(posedge adc_clk);
        @(negedge adc_clk);
        for (int ch = 0; ch < `RP_NCH; ch++) begin
          src = (ch == 0) ? r : DAC_ROWS-1-r;
          check_dac($sformatf("dac row %0d ch%0d", r, ch), code_of(sat_tab[src]),
                    dac_dat_o[ch]);
          if (pass == 1)
            check_adc($sformatf("loop row %0d ch%0d", r, ch), {2'b00, sat_tab[src]},
                      adc_dat_o[ch]);
        end
      end
    end

    // Lock drop of 1 to 16 cycles
    drop_cyc   = int'(lfsr_bits(4)) + 1;
    cnt_before = unlock_cnt_o;
    @(posedge adc_clk);
    pll_locked_i <= 1'b0;
    repeat (drop_cyc) @(posedge adc_clk);
    pll_locked_i <= 1'b1;
    @(negedge adc_clk);
    wait_run(1'b0, RUN_TIMEOUT);
    @(negedge adc_clk);
    verify_idle("lock loss");
    wait_run(1'b1, RUN_TIMEOUT);
    check_count("unlock_cnt_o", unlock_cnt_t'(cnt_before + drop_cyc), unlock_cnt_o);
    @(negedge adc_clk);
    check_bit("relock dac_rst_o", 1'b0, dac_rst_o);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- verilog/rp_adc_front.sv
`timescale 1ns/1ps

`include "rp_params.svh"

module rp_adc_front (
  input  logic                                        adc_clk,
  input  logic                                        rst_n_i,
  input  logic                                        run_i,          // Datapath release
  input  logic                                        digital_loop_i, // DAC to ADC loopback
  input  rp_sample_pkg::adc_raw_t    [`RP_NCH-1:0]    adc_raw_i,
  input  rp_sample_pkg::dac_sample_t [`RP_NCH-1:0]    dac_sat_i,      // Saturated DAC values
  output rp_sample_pkg::adc_sample_t [`RP_NCH-1:0]    adc_dat_o
);

  import rp_sample_pkg::*;

  adc_sample_t [`RP_NCH-1:0] adc_sel; // Converted or looped, before the register

  //////////////////////////////
  // Conversion and loopback
  //////////////////////////////

  always_comb begin
    for (int ch = 0; ch < `RP_NCH; ch++) begin
      if (digital_loop_i) begin
        // DAC value zero padded on top, not sign extended
        adc_sel[ch] = {{(`RP_ADC_W-`RP_DAC_W){1'b0}}, dac_sat_i[ch]};
      end else begin
        // Negative slope to two's complement
        adc_sel[ch] = {adc_raw_i[ch][`RP_ADC_W-1], ~adc_raw_i[ch][`RP_ADC_W-2:0]};
      end
    end
  end

  //////////////////////////////
  // Sample register
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_dat_o <= '0;
    end else if (!run_i) begin
      adc_dat_o <= '0;       // Held at zero until lock settles
    end else begin
      adc_dat_o <= adc_sel;  // One cycle latency
    end
  end

endmodule

//--- verilog/rp_analog_top.sv
`timescale 1ns/1ps

`include "rp_params.svh"

module rp_analog_top (
  input  logic                                        adc_clk,
  input  logic                                        rst_n_i,
  input  logic                                        pll_locked_i,
  input  logic                                        digital_loop_i,
  input  rp_sample_pkg::adc_raw_t    [`RP_NCH-1:0]    adc_raw_i,   // ADC pins
  input  rp_sample_pkg::dac_sample_t [`RP_NCH-1:0]    asg_dat_i,   // Generator
  input  rp_sample_pkg::adc_sample_t [`RP_NCH-1:0]    pid_dat_i,   // Controller
  output rp_sample_pkg::adc_sample_t [`RP_NCH-1:0]    adc_dat_o,
  output rp_sample_pkg::dac_code_t   [`RP_NCH-1:0]    dac_dat_o,   // DAC pins
  output logic                                        dac_rst_o,
  output logic                                        run_o,
  output rp_clock_pkg::unlock_cnt_t                   unlock_cnt_o
);

  import rp_sample_pkg::*;

  logic settle_clr;
  logic settle_en;
  logic settle_done;
  logic lock_lost;

  dac_sample_t [`RP_NCH-1:0] dac_sat; // Loopback path

  //////////////////////////////
  // Clock supervision
  //////////////////////////////

  rp_reset_seq rp_reset_seq_i (
    .adc_clk       (adc_clk),
    .rst_n_i       (rst_n_i),
    .pll_locked_i  (pll_locked_i),
    .settle_done_i (settle_done),
    .settle_clr_o  (settle_clr),
    .settle_en_o   (settle_en),
    .lock_lost_o   (lock_lost),
    .run_o         (run_o),        // Also releases both data modules
    .dac_rst_o     (dac_rst_o)
  );

  rp_lock_timer rp_lock_timer_i (
    .adc_clk       (adc_clk),
    .rst_n_i       (rst_n_i),
    .settle_clr_i  (settle_clr),
    .settle_en_i   (settle_en),
    .lock_lost_i   (lock_lost),
    .settle_done_o (settle_done),
    .unlock_cnt_o  (unlock_cnt_o)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////

  rp_adc_front rp_adc_front_i (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .run_i          (run_o),
    .digital_loop_i (digital_loop_i),
    .adc_raw_i      (adc_raw_i),
    .dac_sat_i      (dac_sat),
    .adc_dat_o      (adc_dat_o)
  );

  rp_dac_back rp_dac_back_i (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .run_i     (run_o),
    .asg_dat_i (asg_dat_i),
    .pid_dat_i (pid_dat_i),
    .dac_sat_o (dac_sat),   // Same cycle as the inputs
    .dac_dat_o (dac_dat_o)
  );

endmodule

//--- verilog/rp_clock_pkg.sv
package rp_clock_pkg;

  `include "rp_params.svh"

  // Reset sequencer states
  typedef enum logic [1:0] {
    SEQ_HOLD   = 2'd0, // Waiting for synchronized lock
    SEQ_SETTLE = 2'd1, // Lock seen, settle timer running
    SEQ_RUN    = 2'd2  // Datapath released
  } seq_state_e;

  // Cycles with the PLL out of lock, wraps
  typedef logic [`RP_CNT_W-1:0] unlock_cnt_t;

endpackage

//--- verilog/rp_dac_back.sv
`timescale 1ns/1ps

`include "rp_params.svh"

module rp_dac_back (
  input  logic                                        adc_clk,
  input  logic                                        rst_n_i,
  input  logic                                        run_i,     // Datapath release
  input  rp_sample_pkg::dac_sample_t [`RP_NCH-1:0]    asg_dat_i, // Generator samples
  input  rp_sample_pkg::adc_sample_t [`RP_NCH-1:0]    pid_dat_i, // Controller samples
  output rp_sample_pkg::dac_sample_t [`RP_NCH-1:0]    dac_sat_o, // To loopback, unregistered
  output rp_sample_pkg::dac_code_t   [`RP_NCH-1:0]    dac_dat_o
);

  import rp_sample_pkg::*;

  // Code for a zero sample, negative slope puts it mid scale
  localparam dac_code_t DAC_ZERO = {1'b0, {(`RP_DAC_W-1){1'b1}}};

  dac_sum_u  [`RP_NCH-1:0] sum;
  dac_code_t [`RP_NCH-1:0] code;

  //////////////////////////////
  // Sum and saturation
  //////////////////////////////

  always_comb begin
    for (int ch = 0; ch < `RP_NCH; ch++) begin
      // Generator sign extended by one, controller top bit dropped
      sum[ch].val = {asg_dat_i[ch][`RP_DAC_W-1], asg_dat_i[ch]}
                  + pid_dat_i[ch][`RP_SUM_W-1:0];

      if (^sum[ch].part.guard) begin
        // Overflow, clamp toward the sign
        dac_sat_o[ch] = {sum[ch].part.guard[1], {(`RP_DAC_W-1){~sum[ch].part.guard[1]}}};
      end else begin
        dac_sat_o[ch] = {sum[ch].part.guard[0], sum[ch].part.body}; // In range
      end

      // Sign kept, magnitude bits inverted
      code[ch] = {dac_sat_o[ch][`RP_DAC_W-1], ~dac_sat_o[ch][`RP_DAC_W-2:0]};
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_dat_o <= {`RP_NCH{DAC_ZERO}};
    end else if (!run_i) begin
      dac_dat_o <= {`RP_NCH{DAC_ZERO}}; // Park at zero output
    end else begin
      dac_dat_o <= code;
    end
  end

endmodule

//--- verilog/rp_lock_timer.sv
`timescale 1ns/1ps

`include "rp_params.svh"

module rp_lock_timer (
  input  logic                      adc_clk,
  input  logic                      rst_n_i,
  input  logic                      settle_clr_i,  // From sequencer, outside settle
  input  logic                      settle_en_i,   // From sequencer, during settle
  input  logic                      lock_lost_i,   // Synchronized lock loss
  output logic                      settle_done_o, // Single cycle
  output rp_clock_pkg::unlock_cnt_t unlock_cnt_o
);

  import rp_clock_pkg::*;

  localparam int unsigned SETTLE_W = $clog2(`RP_SETTLE_CYC + 1);
  localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(`RP_SETTLE_CYC - 1);

  logic [SETTLE_W-1:0] settle_cnt_q;
  unlock_cnt_t         unlock_q;

  //////////////////////////////
  // Settle timer
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      settle_cnt_q <= '0;
    end else if (settle_clr_i) begin
      settle_cnt_q <= '0;                    // Restart on every new settle
    end else if (settle_en_i && (settle_cnt_q != SETTLE_LAST)) begin
      settle_cnt_q <= settle_cnt_q + 1'b1;   // Stops at last count
    end
  end

  // Last settle cycle, sequencer leaves settle right after
  assign settle_done_o = settle_en_i & (settle_cnt_q == SETTLE_LAST);

  //////////////////////////////
  // Unlock diagnostics
  //////////////////////////////

  // One per cycle out of lock, free running wrap
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i)
      unlock_q <= '0;
    else if (lock_lost_i)
      unlock_q <= unlock_q + 1'b1;
  end

  assign unlock_cnt_o = unlock_q;

endmodule

//--- verilog/rp_params.svh
`ifndef RP_PARAMS_SVH
`define RP_PARAMS_SVH

//////////////////////////////
// Sample widths
//////////////////////////////

`define RP_ADC_W 16      // ADC pin word, two lowest bits unused on 14-bit parts
`define RP_DAC_W 14      // DAC code width
`define RP_SUM_W 15      // Generator plus controller sum, one guard bit above DAC

// Two analog channels, A and B
`define RP_NCH 2

//////////////////////////////
// PLL lock supervision
//////////////////////////////

`define RP_CNT_W 32      // Unlock diagnostic counter
`define RP_SETTLE_CYC 16 // Lock must hold this long before the datapath runs

`endif

//--- verilog/rp_reset_seq.sv
`timescale 1ns/1ps

module rp_reset_seq (
  input  logic adc_clk,
  input  logic rst_n_i,
  input  logic pll_locked_i,  // Async from the PLL
  input  logic settle_done_i, // Pulse from the settle timer
  output logic settle_clr_o,
  output logic settle_en_o,
  output logic lock_lost_o,   // Synchronized level
  output logic run_o,
  output logic dac_rst_o      // Active high
);

  import rp_clock_pkg::*;

  logic       lock_meta_q; // First sync stage
  logic       lock_sync_q; // Second sync stage
  logic       lock_seen_q; // Lock reached at least once since reset
  logic       dac_rst_q;
  seq_state_e state_q;
  seq_state_e state_d;

  //////////////////////////////
  // Lock synchronizer
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_meta_q <= 1'b0;
      lock_sync_q <= 1'b0;
      lock_seen_q <= 1'b0;
    end else begin
      lock_meta_q <= pll_locked_i;
      lock_sync_q <= lock_meta_q;
      if (lock_sync_q)
        lock_seen_q <= 1'b1; // Startup before first lock is not a loss
    end
  end

  // Only drops after the first lock count as lost
  assign lock_lost_o = lock_seen_q & ~lock_sync_q;

  //////////////////////////////
  // Sequencer FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    if (!lock_sync_q) begin
      state_d = SEQ_HOLD; // Lock drop wins from any state
    end else begin
      case (state_q)
        SEQ_HOLD:   state_d = SEQ_SETTLE;
        SEQ_SETTLE: if (settle_done_i) state_d = SEQ_RUN;
        SEQ_RUN:    state_d = SEQ_RUN;
        default:    state_d = SEQ_HOLD;
      endcase
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i)
      state_q <= SEQ_HOLD;
    else
      state_q <= state_d;
  end

  // Timer runs only while settling, held clear otherwise
  assign settle_en_o  = (state_q == SEQ_SETTLE);
  assign settle_clr_o = (state_q != SEQ_SETTLE);

  assign run_o = (state_q == SEQ_RUN);

  // DAC reset trails run by one cycle
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i)
      dac_rst_q <= 1'b1;
    else
      dac_rst_q <= ~run_o;
  end

  assign dac_rst_o = dac_rst_q;

endmodule

//--- verilog/rp_sample_pkg.sv
package rp_sample_pkg;

  `include "rp_params.svh"

  //////////////////////////////
  // ADC side
  //////////////////////////////

  // Raw pin word, unsigned with negative slope
  typedef logic [`RP_ADC_W-1:0] adc_raw_t;

  // Converted sample, two's complement
  typedef logic signed [`RP_ADC_W-1:0] adc_sample_t;

  //////////////////////////////
  // DAC side
  //////////////////////////////

  // Generator sample or saturated DAC value
  typedef logic signed [`RP_DAC_W-1:0] dac_sample_t;

  // Unsigned negative-slope code on the DAC pins
  typedef logic [`RP_DAC_W-1:0] dac_code_t;

  // Sum split as top two bits and the rest
  typedef struct packed {
    logic [1:0]            guard; // Differ on overflow
    logic [`RP_SUM_W-3:0]  body;  // Lower 13 bits
  } dac_sum_s;

  // Same 15-bit word, arithmetic view or saturation view
  typedef union packed {
    logic signed [`RP_SUM_W-1:0] val;
    dac_sum_s                    part;
  } dac_sum_u;

endpackage
